/* test/loopback_input.txt */
# cnt rst cfg blk sof crc tmo rxv last data txr leds
# cnt repeats the line, sof 2 toggles each cycle, data rr is random, leds -- is not compared
1 0 0 0 0 0 0 0 0 00 0 3f
2 0 1 0 0 0 0 0 0 00 0 3b
1 0 1 1 0 0 0 1 1 a5 0 --
3 0 1 1 0 0 0 0 0 00 0 --
3 0 1 0 0 0 0 1 0 3c 1 --
2 0 1 1 0 0 0 0 0 00 1 --
1 0 1 1 0 0 0 1 0 3c 1 --
2 0 1 1 0 0 0 0 0 00 1 --
8 0 1 1 0 0 0 1 0 rr 0 --
4 0 1 1 0 0 0 1 1 rr 1 --
12 0 1 1 0 0 0 0 0 00 1 --
64 0 1 1 0 0 0 1 0 rr 0 --
6 0 1 1 0 0 0 1 0 rr 1 --
3 0 0 1 0 0 0 0 0 00 0 --
80 0 1 1 0 0 0 0 0 00 1 --
16 0 1 0 2 0 0 0 0 00 0 3b
1 0 1 0 0 0 0 0 0 00 0 1b
1 0 1 0 0 0 1 0 0 00 0 1b
1 0 1 0 0 0 0 0 0 00 0 0b
1 0 1 0 0 1 0 0 0 00 0 0b
1 0 1 0 0 0 0 0 0 00 0 2b
8 0 1 0 2 0 0 0 0 00 0 2b
1 0 1 0 0 0 0 0 0 00 0 0b
4 1 0 0 0 0 0 0 0 00 0 3f
1 0 0 0 0 0 0 0 0 00 0 3f
1 0 1 0 0 0 0 0 0 00 0 3b
1 0 1 1 0 0 0 1 1 rr 1 --
3 0 1 1 0 0 0 0 0 00 1 --

/* filelist.f */
rtl/usb_loop_pkg.sv
rtl/bulk_loop_fifo.sv
rtl/bulk_endpoint_status.sv
rtl/usb_activity_leds.sv
rtl/usb_loopback_top.sv
test/usb_loopback_assert.sv
test/usb_loopback_checker.sv
test/tb_usb_loopback.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_usb_loopback
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_TEXT := No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only when the pass line shows up in the output
sim: build
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^$(PASS_TEXT)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_usb_loopback.sv */
`timescale 1ns/10ps

module tb_usb_loopback
  import usb_loop_pkg::*;
();

  localparam int    MAX_LINES  = 64;
  localparam int    SEED       = 91309;
  localparam string INPUT_FILE = "test/loopback_input.txt";

  logic       usb_clock;
  logic       usb_reset;
  logic       configured;
  logic       blk_cycle;
  logic       usb_sof;
  logic       crc_err;
  logic       timeout;
  logic       rx_valid;
  usb_byte_t  rx_byte;
  logic       rx_ready;
  logic       tx_valid;
  usb_byte_t  tx_byte;
  logic       tx_ready;
  logic       blk_in_ready;
  logic       blk_out_ready;
  logic [5:0] leds;

  logic       line_first;
  logic       line_chk;
  logic [5:0] line_leds;
  logic       rx_accept;
  int         checker_errors;
  int         tb_errors = 0;
  int         watch_cycles = 0;

  // One entry per data file line
  int         num_lines = 0;
  int         line_cnt  [MAX_LINES];
  logic       line_rst  [MAX_LINES];
  logic       line_cfg  [MAX_LINES];
  logic       line_blk  [MAX_LINES];
  logic [1:0] line_sof  [MAX_LINES];
  logic       line_crc  [MAX_LINES];
  logic       line_tmo  [MAX_LINES];
  logic       line_rxv  [MAX_LINES];
  logic       line_last [MAX_LINES];
  logic       line_rand [MAX_LINES];
  logic [7:0] line_data [MAX_LINES];
  logic       line_txr  [MAX_LINES];
  logic       line_has_leds [MAX_LINES];
  logic [5:0] line_exp_leds [MAX_LINES];

  usb_loopback_top usb_loopback_top_i (
    .usb_clock      (usb_clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured),
    .blk_cycle_i    (blk_cycle),
    .usb_sof_i      (usb_sof),
    .crc_err_i      (crc_err),
    .timeout_i      (timeout),
    .rx_valid_i     (rx_valid),
    .rx_byte_i      (rx_byte),
    .rx_ready_o     (rx_ready),
    .tx_valid_o     (tx_valid),
    .tx_byte_o      (tx_byte),
    .tx_ready_i     (tx_ready),
    .blk_in_ready_o (blk_in_ready),
    .blk_out_ready_o(blk_out_ready),
    .leds_o         (leds)
  );

  usb_loopback_checker usb_loopback_checker_i (
    .usb_clock      (usb_clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured),
    .blk_cycle_i    (blk_cycle),
    .usb_sof_i      (usb_sof),
    .crc_err_i      (crc_err),
    .timeout_i      (timeout),
    .rx_valid_i     (rx_valid),
    .rx_byte_i      (rx_byte),
    .rx_ready_i     (rx_ready),
    .tx_valid_i     (tx_valid),
    .tx_byte_i      (tx_byte),
    .tx_ready_i     (tx_ready),
    .blk_in_ready_i (blk_in_ready),
    .blk_out_ready_i(blk_out_ready),
    .leds_i         (leds),
    .line_first_i   (line_first),
    .line_chk_i     (line_chk),
    .line_leds_i    (line_leds),
    .rx_accept_o    (rx_accept),
    .err_count_o    (checker_errors)
  );

  bind bulk_loop_fifo usb_loopback_assert fifo_assert_i (
    .usb_clock  (usb_clock),
    .usb_reset  (usb_reset),
    .blk_cycle_i(blk_cycle_i),
    .in_ready_o (in_ready_o),
    .out_valid_o(out_valid_o),
    .out_byte_o (out_byte_o),
    .out_ready_i(out_ready_i),
    .level_o    (level_o)
  );

  initial begin
    usb_clock = 1'b0;
    forever #5 usb_clock = ~usb_clock;
  end

  task automatic read_stimulus();
    int    fd;
    int    code;
    string text;
    string data_s;
    string leds_s;
    int    cnt, rst, cfg, blk, sof, crc, tmo, rxv, last, txr, val;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", INPUT_FILE);
      tb_errors++;
      return;
    end
    while (!$feof(fd) && num_lines < MAX_LINES) begin
      code = $fgets(text, fd);
      if (code == 0 || text.len() < 2 || text[0] == 8'h23)
        continue;
      code = $sscanf(text, "%d %d %d %d %d %d %d %d %d %s %d %s", cnt, rst, cfg, blk,
                     sof, crc, tmo, rxv, last, data_s, txr, leds_s);
      if (code != 12) begin
        $display("Skipped a malformed stimulus line: %s", text);
        tb_errors++;
        continue;
      end
      line_cnt[num_lines]  = cnt;
      line_rst[num_lines]  = rst[0];
      line_cfg[num_lines]  = cfg[0];
      line_blk[num_lines]  = blk[0];
      line_sof[num_lines]  = sof[1:0];
      line_crc[num_lines]  = crc[0];
      line_tmo[num_lines]  = tmo[0];
      line_rxv[num_lines]  = rxv[0];
      line_last[num_lines] = last[0];
      line_txr[num_lines]  = txr[0];
      line_rand[num_lines] = (data_s == "rr");
      val = 0;
      if (data_s != "rr")
        code = $sscanf(data_s, "%h", val);
      line_data[num_lines] = 8'(val);
      line_has_leds[num_lines] = (leds_s != "--");
      val = 0;
      if (leds_s != "--")
        code = $sscanf(leds_s, "%h", val);
      line_exp_leds[num_lines] = 6'(val);
      watch_cycles += cnt * 4;
      num_lines++;
    end
    $fclose(fd);
  endtask

  // sof value 2 toggles the pin every application of the line
  task automatic run_line(input int idx);
    int n;
    for (n = 0; n < line_cnt[idx]; n++) begin
      usb_reset    = line_rst[idx];
      configured   = line_cfg[idx];
      blk_cycle    = line_blk[idx];
      usb_sof      = (line_sof[idx] == 2'd2) ? n[0] : line_sof[idx][0];
      crc_err      = line_crc[idx];
      timeout      = line_tmo[idx];
      rx_valid     = line_rxv[idx];
      rx_byte.last = line_last[idx];
      rx_byte.data = line_rand[idx] ? 8'($urandom) : line_data[idx];
      tx_ready     = line_txr[idx];
      line_first   = (n == 0);
      line_chk     = line_has_leds[idx];
      line_leds    = line_exp_leds[idx];
      @(posedge usb_clock);
      // Offered byte stays put until the checker sees it taken
      while (rx_valid && blk_cycle && !rx_accept) begin
        #1;
        line_first = 1'b0;
        @(posedge usb_clock);
      end
      #1;
    end
  endtask

  initial begin
    usb_reset    = 1'b1;
    configured   = 1'b0;
    blk_cycle    = 1'b0;
    usb_sof      = 1'b0;
    crc_err      = 1'b0;
    timeout      = 1'b0;
    rx_valid     = 1'b0;
    rx_byte      = '0;
    tx_ready     = 1'b0;
    line_first   = 1'b0;
    line_chk     = 1'b0;
    line_leds    = 6'h3f;
    void'($urandom(SEED));
    read_stimulus();
    watch_cycles += 100;

    repeat (4) @(posedge usb_clock);
    #1;
    usb_reset = 1'b0;

    for (int i = 0; i < num_lines; i++)
      run_line(i);

    rx_valid = 1'b0;
    repeat (4) @(posedge usb_clock);
    #1;
    $display("Run complete, %0d errors counted", tb_errors + checker_errors);
    if (tb_errors + checker_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog
  initial begin
    #1;
    repeat (watch_cycles) @(posedge usb_clock);
    $display("Timeout: the run did not finish within %0d clock cycles", watch_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

/* test/usb_loopback_checker.sv */
`timescale 1ns/10ps

module usb_loopback_checker
  import usb_loop_pkg::*;
(
  input  logic       usb_clock,
  input  logic       usb_reset,
  input  logic       configured_i,
  input  logic       blk_cycle_i,
  input  logic       usb_sof_i,
  input  logic       crc_err_i,
  input  logic       timeout_i,
  input  logic       rx_valid_i,
  input  usb_byte_t  rx_byte_i,
  input  logic       rx_ready_i,
  input  logic       tx_valid_i,
  input  usb_byte_t  tx_byte_i,
  input  logic       tx_ready_i,
  input  logic       blk_in_ready_i,
  input  logic       blk_out_ready_i,
  input  logic [5:0] leds_i,
  input  logic       line_first_i,
  input  logic       line_chk_i,
  input  logic [5:0] line_leds_i,
  output logic       rx_accept_o,
  output int         err_count_o
);

  usb_byte_t            byte_queue[$];
  int                   level = 0;
  int                   errors = 0;
  logic                 active = 1'b0;
  logic [BLINK_BIT+1:0] sof_count;
  logic                 sof_prev;
  logic                 timeout_seen;
  led_mode_e            mode;
  logic                 exp_in_ready;
  logic                 exp_out_ready;
  logic [5:0]           exp_leds;
  logic                 file_pending = 1'b0;
  logic [5:0]           file_leds;
  logic                 accept;
  logic                 deliver;
  logic                 blink;

  assign err_count_o = errors;

  task automatic report_mismatch(input string name, input logic [8:0] expected,
                                 input logic [8:0] actual);
    errors++;
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  // Everything is sampled mid-cycle, where inputs and outputs are settled
  always @(negedge usb_clock) begin
    if (active) begin
      if (rx_ready_i !== (level != FIFO_DEPTH))
        report_mismatch("rx_ready_o", 9'(level != FIFO_DEPTH), 9'(rx_ready_i));
      // Output register is full whenever anything is stored
      if (tx_valid_i !== (level != 0))
        report_mismatch("tx_valid_o", 9'(level != 0), 9'(tx_valid_i));
      if (tx_valid_i === 1'b1 && byte_queue.size() > 0 && tx_byte_i !== byte_queue[0])
        report_mismatch("tx_byte_o", byte_queue[0], tx_byte_i);
      if (blk_in_ready_i !== exp_in_ready)
        report_mismatch("blk_in_ready_o", 9'(exp_in_ready), 9'(blk_in_ready_i));
      if (blk_out_ready_i !== exp_out_ready)
        report_mismatch("blk_out_ready_o", 9'(exp_out_ready), 9'(blk_out_ready_i));
      if (leds_i !== exp_leds)
        report_mismatch("leds_o", 9'(exp_leds), 9'(leds_i));
      if (file_pending && leds_i !== file_leds)
        report_mismatch("leds_o (data file)", 9'(file_leds), 9'(leds_i));
    end

    file_pending = line_first_i && line_chk_i;
    file_leds = line_leds_i;

    if (usb_reset) begin
      active = 1'b1;
      level = 0;
      byte_queue.delete();
      sof_count = '0;
      sof_prev = 1'b0;
      timeout_seen = 1'b0;
      mode = LED_NORMAL;
      exp_in_ready = 1'b0;
      exp_out_ready = 1'b0;
      exp_leds = 6'h3f;
      rx_accept_o = 1'b0;
    end else begin
      accept = blk_cycle_i && rx_valid_i && rx_ready_i;
      deliver = blk_cycle_i && tx_valid_i && tx_ready_i;

      // LEDs show the current state on the next edge
      // In-ready LED takes the flag value expected in this cycle
      if (mode == LED_CRC_FAULT)
        blink = sof_count[BLINK_BIT] && sof_count[BLINK_BIT+1];
      else
        blink = sof_count[BLINK_BIT+1];
      exp_leds = {~blink, ~timeout_seen, ~exp_in_ready, ~configured_i, 2'b11};

      // Flags follow the current level on the next edge
      exp_in_ready = configured_i && (level > IN_READY_MIN);
      exp_out_ready = configured_i && (level < OUT_READY_MAX);

      if (timeout_i)
        timeout_seen = 1'b1;
      if (crc_err_i)
        mode = LED_CRC_FAULT;
      if (usb_sof_i && !sof_prev)
        sof_count = sof_count + 1'b1;
      sof_prev = usb_sof_i;

      if (accept)
        byte_queue.push_back(rx_byte_i);
      if (deliver && byte_queue.size() > 0)
        void'(byte_queue.pop_front());
      level = level + int'(accept) - int'(deliver);
      rx_accept_o = accept;
    end
  end

endmodule

/* test/usb_loopback_assert.sv */
`timescale 1ns/10ps

module usb_loopback_assert
  import usb_loop_pkg::*;
(
  input logic               usb_clock,
  input logic               usb_reset,
  input logic               blk_cycle_i,
  input logic               in_ready_o,
  input logic               out_valid_o,
  input usb_byte_t          out_byte_o,
  input logic               out_ready_i,
  input logic [LEVEL_W-1:0] level_o
);

  // A waiting output byte keeps its value until it is taken
  property hold_out_byte;
    @(posedge usb_clock) disable iff (usb_reset)
      (out_valid_o && !(blk_cycle_i && out_ready_i)) |=> (out_valid_o && $stable(out_byte_o));
  endproperty

  // Full FIFO keeps refusing input until a byte leaves
  property full_blocks_input;
    @(posedge usb_clock) disable iff (usb_reset)
      (level_o == LEVEL_W'(FIFO_DEPTH) && !(blk_cycle_i && out_valid_o && out_ready_i))
        |=> (level_o == LEVEL_W'(FIFO_DEPTH) && !in_ready_o);
  endproperty

  property empty_after_reset;
    @(posedge usb_clock) usb_reset |=> !out_valid_o;
  endproperty

  hold_out_byte_a: assert property (hold_out_byte)
    else $error("output byte changed or vanished before it was transferred");
  full_blocks_input_a: assert property (full_blocks_input)
    else $error("FIFO left the full state or took input without a byte leaving");
  empty_after_reset_a: assert property (empty_after_reset)
    else $error("out_valid_o high in the cycle after reset");

endmodule

/* rtl/usb_loopback_top.sv */
`timescale 1ns/10ps

module usb_loopback_top
  import usb_loop_pkg::*;
(
  input  logic      usb_clock,
  input  logic      usb_reset,

  // Status from the USB core
  input  logic      configured_i,
  input  logic      blk_cycle_i,
  input  logic      usb_sof_i,
  input  logic      crc_err_i,
  input  logic      timeout_i,

  // Bulk OUT data from the core
  input  logic      rx_valid_i,
  input  usb_byte_t rx_byte_i,
  output logic      rx_ready_o,

  // Bulk IN data back to the core
  output logic      tx_valid_o,
  output usb_byte_t tx_byte_o,
  input  logic      tx_ready_i,

  // Endpoint flags to the core
  output logic      blk_in_ready_o,
  output logic      blk_out_ready_o,

  output logic [5:0] leds_o
);

  logic [LEVEL_W-1:0] level_w;

  bulk_loop_fifo bulk_loop_fifo_i (
    .usb_clock  (usb_clock),
    .usb_reset  (usb_reset),
    .blk_cycle_i(blk_cycle_i),
    .in_valid_i (rx_valid_i),
    .in_byte_i  (rx_byte_i),
    .in_ready_o (rx_ready_o),
    .out_valid_o(tx_valid_o),
    .out_byte_o (tx_byte_o),
    .out_ready_i(tx_ready_i),
    .level_o    (level_w)
  );

  bulk_endpoint_status bulk_endpoint_status_i (
    .usb_clock      (usb_clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured_i),
    .level_i        (level_w),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_ready_o(blk_out_ready_o)
  );

  // IN-ready flag also drives one of the LEDs
  usb_activity_leds usb_activity_leds_i (
    .usb_clock     (usb_clock),
    .usb_reset     (usb_reset),
    .configured_i  (configured_i),
    .usb_sof_i     (usb_sof_i),
    .crc_err_i     (crc_err_i),
    .timeout_i     (timeout_i),
    .blk_in_ready_i(blk_in_ready_o),
    .leds_o        (leds_o)
  );

endmodule

/* rtl/usb_activity_leds.sv */
`timescale 1ns/10ps

module usb_activity_leds
  import usb_loop_pkg::*;
(
  input  logic       usb_clock,
  input  logic       usb_reset,
  input  logic       configured_i,
  input  logic       usb_sof_i,
  input  logic       crc_err_i,
  input  logic       timeout_i,
  input  logic       blk_in_ready_i,
  output logic [5:0] leds_o
);

  logic                 sof_q;
  logic [BLINK_BIT+1:0] sof_count_q;
  logic                 timeout_q;
  led_mode_e            mode_q;
  logic                 blink;
  logic [5:0]           leds_q;

  // SOF edge counter
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      sof_q       <= 1'b0;
      sof_count_q <= '0;
    end else begin
      sof_q <= usb_sof_i;
      if (usb_sof_i && !sof_q) begin
        sof_count_q <= sof_count_q + 1'b1;
      end
    end
  end

  // Error latches, cleared only by reset
  // The mode register doubles as the CRC latch
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      timeout_q <= 1'b0;
      mode_q    <= LED_NORMAL;
    end else begin
      if (timeout_i) begin
        timeout_q <= 1'b1;
      end
      if (crc_err_i) begin
        mode_q <= LED_CRC_FAULT;
      end
    end
  end

  // Short blips once a CRC error has been seen
  always_comb begin
    case (mode_q)
      LED_CRC_FAULT: blink = sof_count_q[BLINK_BIT] & sof_count_q[BLINK_BIT+1];
      default:       blink = sof_count_q[BLINK_BIT+1];
    endcase
  end

  // Active low, two LEDs unused
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      leds_q <= 6'b111111;
    end else begin
      leds_q <= {~blink, ~timeout_q, ~blk_in_ready_i, ~configured_i, 2'b11};
    end
  end

  assign leds_o = leds_q;

endmodule

/* rtl/bulk_endpoint_status.sv */
`timescale 1ns/10ps

module bulk_endpoint_status
  import usb_loop_pkg::*;
(
  input  logic               usb_clock,
  input  logic               usb_reset,
  input  logic               configured_i,
  input  logic [LEVEL_W-1:0] level_i,
  output logic               blk_in_ready_o,
  output logic               blk_out_ready_o
);

  logic in_ready_q;
  logic out_ready_q;

  // Flags to the core, one cycle behind the FIFO level
  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      in_ready_q  <= 1'b0;
      out_ready_q <= 1'b0;
    end else begin
      // Enough queued to be worth an IN transfer
      in_ready_q  <= configured_i && (level_i > LEVEL_W'(IN_READY_MIN));
      // Room left for another OUT packet
      out_ready_q <= configured_i && (level_i < LEVEL_W'(OUT_READY_MAX));
    end
  end

  assign blk_in_ready_o  = in_ready_q;
  assign blk_out_ready_o = out_ready_q;

endmodule

/* rtl/bulk_loop_fifo.sv */
`timescale 1ns/10ps

module bulk_loop_fifo
  import usb_loop_pkg::*;
(
  input  logic               usb_clock,
  input  logic               usb_reset,
  input  logic               blk_cycle_i,
  input  logic               in_valid_i,
  input  usb_byte_t          in_byte_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output usb_byte_t          out_byte_o,
  input  logic               out_ready_i,
  output logic [LEVEL_W-1:0] level_o
);

  // Storage behind the output register
  usb_byte_t mem [FIFO_DEPTH];

  logic [FIFO_ABITS-1:0] wr_ptr_q;
  logic [FIFO_ABITS-1:0] rd_ptr_q;
  logic [LEVEL_W-1:0]    level_q;
  logic                  out_valid_q;
  usb_byte_t             out_byte_q;

  logic               wr_fire;
  logic               rd_fire;
  logic               out_free;
  logic [LEVEL_W-1:0] ram_count;
  logic               ram_empty;
  logic               bypass;
  logic               load;

  // Both sides only move during a bulk cycle
  assign wr_fire = blk_cycle_i && in_valid_i && in_ready_o;
  assign rd_fire = blk_cycle_i && out_valid_q && out_ready_i;

  // Output register can take a byte on this edge
  assign out_free = !out_valid_q || rd_fire;

  // Level includes the output register, the RAM holds the rest
  assign ram_count = level_q - LEVEL_W'(out_valid_q);
  assign ram_empty = (ram_count == '0);

  // Write straight into the output register when nothing is queued ahead
  assign bypass = wr_fire && out_free && ram_empty;
  assign load   = out_free && !ram_empty;

  assign in_ready_o  = (level_q != LEVEL_W'(FIFO_DEPTH));
  assign out_valid_o = out_valid_q;
  assign out_byte_o  = out_byte_q;
  assign level_o     = level_q;

  always_ff @(posedge usb_clock) begin
    if (wr_fire && !bypass) begin
      mem[wr_ptr_q] <= in_byte_i;
    end
  end

  // Payload only changes when the register is free, so a waiting byte holds
  always_ff @(posedge usb_clock) begin
    if (bypass) begin
      out_byte_q <= in_byte_i;
    end else if (load) begin
      out_byte_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge usb_clock) begin
    if (usb_reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      level_q     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (wr_fire && !bypass) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end

      if (load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      // Refill or bypass wins over the consumed byte
      if (bypass || load) begin
        out_valid_q <= 1'b1;
      end else if (rd_fire) begin
        out_valid_q <= 1'b0;
      end

      case ({wr_fire, rd_fire})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

/* rtl/usb_loop_pkg.sv */
package usb_loop_pkg;

  // One byte of a bulk data stream, with the end-of-frame marker
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } usb_byte_t;

  // Loopback FIFO geometry
  localparam int FIFO_ABITS = 6;
  localparam int FIFO_DEPTH = 64;

  // Level has to reach FIFO_DEPTH itself, so one bit wider than the pointers
  localparam int LEVEL_W = FIFO_ABITS + 1;

  // Endpoint ready thresholds, in bytes held by the FIFO
  // IN-ready needs more than this many bytes waiting
  localparam int IN_READY_MIN = 4;

  // OUT-ready needs fewer than this many bytes waiting
  localparam int OUT_READY_MAX = 48;

  // Lowest SOF count bit that takes part in the blink
  localparam int BLINK_BIT = 2;

  // Blink pattern selector
  typedef enum logic {
    LED_NORMAL,
    LED_CRC_FAULT
  } led_mode_e;

endpackage
